//--- mdio_ctrl.f
+incdir+design
design/mdio_ctrl_pkg.sv
design/mdio_reg_decode.sv
design/mdio_frame_engine.sv
design/mdio_irq_status.sv
design/mdio_ctrl.sv
tests/mdio_ctrl_sva.sv
tests/mdio_ctrl_tb.sv

//--- Makefile
# Verilator build and run of the MDIO controller testbench

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -f mdio_ctrl.f --top-module mdio_ctrl_tb -Mdir obj_dir
	-./obj_dir/Vmdio_ctrl_tb +verilator+error+limit+100 > sim.log 2>&1
	@cat sim.log
	@grep -q "^ALL TESTS PASSED$$" sim.log

clean:
	rm -rf obj_dir sim.log

//--- tests/mdio_ctrl_tb.sv
/*
 * Testbench for the MDIO controller
 * Clock and reset, AXI-Lite host tasks, PHY model on the MDIO line,
 * self-checking tests and the final report
 */
`timescale 1ns/100ps
`include "mdio_ctrl_consts.svh"

module mdio_ctrl_tb import mdio_ctrl_pkg::*; ();

    logic        clock;
    logic        reset;
    axil_req_t   axil_req;
    axil_rsp_t   axil_rsp;
    mdio_pins_t  mdio_pins;
    logic        mdio_in = 1'b1;
    logic        phy_irq;
    logic        mdio_reset;
    logic        irq_out;

    // PHY model state
    int          phy_edges = 0;
    logic        mdc_prev = 1'b0;
    logic        oe_prev = 1'b0;
    logic [63:0] seen_bits = '0;
    mdio_frame_t read_pattern = '0;

    integer      seed;
    int          errors = 0;
    int          errors_before = 0;
    int          checks = 0;
    int          tests_run = 0;
    int          tests_failed = 0;

    mdio_ctrl mdio_ctrl_i (
        .clock        (clock),
        .reset        (reset),
        .axil_req_i   (axil_req),
        .axil_rsp_o   (axil_rsp),
        .mdio_pins_o  (mdio_pins),
        .mdio_i       (mdio_in),
        .phy_irq_i    (phy_irq),
        .mdio_reset_o (mdio_reset),
        .interrupt_o  (irq_out)
    );

    bind mdio_frame_engine mdio_ctrl_sva sva_i (
        .clock   (clock),
        .reset   (reset),
        .start   (mdio_cmd_i.start),
        .done    (mdio_rsp_o.done),
        .mdc     (mdio_pins_o.mdc),
        .data_oe (mdio_pins_o.data_oe),
        .read_op (frame_q[`MDIO_READ_OP_BIT]),
        .bit_pos (bit_q)
    );

    initial begin
        clock = 1'b0;
        forever begin
            #50 clock = ~clock;
        end
    end

    // PHY model echoes the driven line and answers with the pattern once released
    always @(negedge clock) begin
        if (mdio_pins.data_oe && !oe_prev) begin
            phy_edges = 0;
        end
        oe_prev = mdio_pins.data_oe;
        if (mdio_pins.mdc && !mdc_prev && phy_edges < 64) begin
            seen_bits[6'(63 - phy_edges)] = mdio_in;
            phy_edges = phy_edges + 1;
        end
        mdc_prev = mdio_pins.mdc;
        if (mdio_pins.data_oe) begin
            mdio_in = mdio_pins.data_out;
        end else if (phy_edges >= 32 && phy_edges < 64) begin
            mdio_in = read_pattern[5'(63 - phy_edges)];
        end else begin
            mdio_in = 1'b1;
        end
    end

    task automatic stop_on_timeout(input string what);
        $display("Timeout at %0t: %s", $time, what);
        $display("SOME TESTS FAILED");
        $finish;
    endtask

    task automatic expect_word(input string name, input reg_word_t got, input reg_word_t exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("ERR %0t %s expected %h got %h", $time, name, exp, got);
        end
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors != errors_before) begin
            tests_failed++;
            $display("test %0d %s: failed", tests_run, name);
        end else begin
            $display("test %0d %s: passed", tests_run, name);
        end
        errors_before = errors;
    endtask

    task automatic axil_write(input reg_addr_t addr, input reg_word_t data);
        int   waited;
        logic aw_taken;
        logic w_taken;
        axil_req.awaddr  = addr;
        axil_req.awvalid = 1'b1;
        axil_req.wdata   = data;
        axil_req.wvalid  = 1'b1;
        waited = 0;
        while (axil_req.awvalid || axil_req.wvalid) begin
            // Ready seen now means accepted at the next rising edge
            aw_taken = axil_req.awvalid && axil_rsp.awready;
            w_taken  = axil_req.wvalid && axil_rsp.wready;
            @(negedge clock);
            if (aw_taken) begin
                axil_req.awvalid = 1'b0;
            end
            if (w_taken) begin
                axil_req.wvalid = 1'b0;
            end
            waited++;
            if (waited > 20) begin
                stop_on_timeout("the write address or data was never accepted");
            end
        end
        waited = 0;
        while (!axil_rsp.bvalid) begin
            @(negedge clock);
            waited++;
            if (waited > 20) begin
                stop_on_timeout("no write response arrived");
            end
        end
        expect_word("bresp", 32'(axil_rsp.bresp), 32'h0);
    endtask

    task automatic axil_read(input reg_addr_t addr, output reg_word_t data);
        int   waited;
        logic taken;
        axil_req.araddr  = addr;
        axil_req.arvalid = 1'b1;
        waited = 0;
        while (axil_req.arvalid) begin
            taken = axil_rsp.arready;
            @(negedge clock);
            if (taken) begin
                axil_req.arvalid = 1'b0;
            end
            waited++;
            if (waited > 20) begin
                stop_on_timeout("the read address was never accepted");
            end
        end
        waited = 0;
        while (!axil_rsp.rvalid) begin
            @(negedge clock);
            waited++;
            if (waited > 20) begin
                stop_on_timeout("no read data arrived");
            end
        end
        expect_word("rresp", 32'(axil_rsp.rresp), 32'h0);
        data = axil_rsp.rdata;
    endtask

    // Poll the status word until the engine is idle again
    task automatic wait_idle();
        reg_word_t status;
        int        polls;
        status = '0;
        polls = 0;
        while (!status[`IRQ_MDIO_IDLE_BIT]) begin
            axil_read(`REG_INT_STATUS, status);
            polls++;
            if (polls > 2000) begin
                stop_on_timeout("the MDIO frame never finished");
            end
        end
    endtask

    initial begin
        reg_word_t data;
        reg_word_t value;
        int        waited;
        seed = 67;
        reset = 1'b1;
        axil_req = '0;
        axil_req.bready = 1'b1;
        axil_req.rready = 1'b1;
        phy_irq = 1'b0;
        repeat (5) @(negedge clock);
        reset = 1'b0;

        axil_read(`REG_INT_ENABLE, data);
        expect_word("int_enable", data, 32'h0);
        axil_read(`REG_MDIO_RESULT, data);
        expect_word("mdio_result", data, 32'h0);
        axil_read(`REG_INT_STATUS, data);
        expect_word("int_status", data, 32'h1 << `IRQ_MDIO_IDLE_BIT);
        expect_word("interrupt_o", 32'(irq_out), 32'h0);
        expect_word("mdio_reset_o", 32'(mdio_reset), 32'h1);
        end_test("reset values");

        repeat (3) begin
            value = $random(seed);
            axil_write(`REG_INT_ENABLE, value);
            axil_read(`REG_INT_ENABLE, data);
            expect_word("int_enable", data, value);
        end
        axil_write(`REG_INT_ENABLE, 32'h0);
        axil_write(`REG_CONTROL, 32'h4);
        expect_word("mdio_reset_o", 32'(mdio_reset), 32'h0);
        axil_write(`REG_CONTROL, 32'h0);
        expect_word("mdio_reset_o", 32'(mdio_reset), 32'h1);
        axil_write(12'h100, 32'hFFFF_FFFF);
        axil_read(12'h100, data);
        expect_word("unused offset", data, 32'h0);
        end_test("register round trip");

        value = $random(seed) & ~(32'h1 << `MDIO_READ_OP_BIT);
        axil_write(`REG_MDIO_CMD, value);
        wait_idle();
        expect_word("preamble", seen_bits[63:32], 32'hFFFF_FFFF);
        expect_word("frame bits", seen_bits[31:0], value);
        axil_read(`REG_MDIO_RESULT, data);
        expect_word("mdio_result", data, value);
        end_test("write frame");

        // Line is released from frame bit 46 so result bits 17..0 come from the PHY
        value = $random(seed) | (32'h1 << `MDIO_READ_OP_BIT);
        read_pattern = $random(seed);
        axil_write(`REG_MDIO_CMD, value);
        wait_idle();
        axil_read(`REG_MDIO_RESULT, data);
        expect_word("mdio_result", data, {value[31:18], read_pattern[17:0]});
        end_test("read frame");

        axil_write(`REG_INT_ENABLE, 32'h1 << `IRQ_MDIO_IDLE_BIT);
        expect_word("interrupt_o", 32'(irq_out), 32'h1);
        value = $random(seed) & ~(32'h1 << `MDIO_READ_OP_BIT);
        axil_write(`REG_MDIO_CMD, value);
        expect_word("interrupt_o", 32'(irq_out), 32'h0);
        wait_idle();
        expect_word("interrupt_o", 32'(irq_out), 32'h1);
        axil_write(`REG_INT_ENABLE, 32'h1 << `IRQ_PHY_BIT);
        expect_word("interrupt_o", 32'(irq_out), 32'h0);
        phy_irq = 1'b1;
        waited = 0;
        while (!irq_out) begin
            @(negedge clock);
            waited++;
            if (waited > 10) begin
                stop_on_timeout("the PHY interrupt never reached interrupt_o");
            end
        end
        axil_read(`REG_INT_STATUS, data);
        expect_word("int_status", data,
            (32'h1 << `IRQ_PHY_BIT) | (32'h1 << `IRQ_MDIO_IDLE_BIT));
        axil_write(`REG_INT_ENABLE, 32'h0);
        expect_word("interrupt_o", 32'(irq_out), 32'h0);
        phy_irq = 1'b0;
        end_test("interrupts");

        value = $random(seed);
        axil_write(`REG_INT_ENABLE, value);
        axil_req.rready = 1'b0;
        axil_read(`REG_INT_ENABLE, data);
        expect_word("rdata", data, value);
        repeat (6) begin
            @(negedge clock);
            expect_word("rvalid", 32'(axil_rsp.rvalid), 32'h1);
            expect_word("rdata", axil_rsp.rdata, value);
            expect_word("arready", 32'(axil_rsp.arready), 32'h0);
        end
        axil_req.rready = 1'b1;
        @(negedge clock);
        expect_word("rvalid", 32'(axil_rsp.rvalid), 32'h0);
        expect_word("arready", 32'(axil_rsp.arready), 32'h1);
        axil_write(`REG_INT_ENABLE, 32'h0);
        end_test("back-pressure");

        errors = errors + mdio_ctrl_i.frame_engine_i.sva_i.failures;
        $display("tests %0d, failed %0d, checks %0d, errors %0d",
            tests_run, tests_failed, checks, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- tests/mdio_ctrl_sva.sv
/*
 * Concurrent checks on the MDIO frame engine
 * MDC high phase, line release and the done level
 */
`timescale 1ns/100ps
`include "mdio_ctrl_consts.svh"

module mdio_ctrl_sva import mdio_ctrl_pkg::*; (
    input logic       clock,
    input logic       reset,
    input logic       start,
    input logic       done,
    input logic       mdc,
    input logic       data_oe,
    input logic       read_op,
    input frame_bit_t bit_pos
);

    int failures = 0;

    // Every rise of MDC is followed by a fall exactly one phase later
    mdc_rise_to_fall: assert property (@(posedge clock) disable iff (reset)
        $rose(mdc) |-> ##(`MDC_HALF_PERIOD) $fell(mdc))
    else begin
        failures++;
        $error("MDC high phase did not end after %0d clocks", `MDC_HALF_PERIOD);
    end

    // and every fall had its rise one phase before
    mdc_fall_after_rise: assert property (@(posedge clock) disable iff (reset)
        $fell(mdc) |-> $past(mdc, `MDC_HALF_PERIOD) && !$past(mdc, `MDC_HALF_PERIOD + 1))
    else begin
        failures++;
        $error("MDC high phase was shorter than %0d clocks", `MDC_HALF_PERIOD);
    end

    // Release only in the data part of a read, or on return to idle
    oe_release: assert property (@(posedge clock) disable iff (reset)
        $fell(data_oe) |-> !start || (read_op && bit_pos >= frame_bit_t'(`MDIO_RELEASE_BIT)))
    else begin
        failures++;
        $error("MDIO line released outside the data part of a read frame");
    end

    done_needs_start: assert property (@(posedge clock) disable iff (reset)
        $rose(done) |-> start)
    else begin
        failures++;
        $error("Frame done rose while start was low");
    end

endmodule

//--- design/mdio_ctrl.sv
/*
 * MDIO controller top level
 * AXI-Lite register slave, frame engine and interrupt status
 */
`timescale 1ns/100ps

module mdio_ctrl import mdio_ctrl_pkg::*; (
    input  logic       clock,
    input  logic       reset,
    input  axil_req_t  axil_req_i,
    output axil_rsp_t  axil_rsp_o,
    output mdio_pins_t mdio_pins_o,
    input  logic       mdio_i,
    input  logic       phy_irq_i,
    output logic       mdio_reset_o,
    output logic       interrupt_o
);

    mdio_cmd_t mdio_cmd;
    mdio_rsp_t mdio_rsp;
    reg_word_t irq_status;
    reg_word_t irq_enable;

    mdio_reg_decode reg_decode_i (
        .clock         (clock),
        .reset         (reset),
        .axil_req_i    (axil_req_i),
        .axil_rsp_o    (axil_rsp_o),
        .mdio_cmd_o    (mdio_cmd),
        .mdio_done_i   (mdio_rsp.done),
        .mdio_result_i (mdio_rsp.result),
        .irq_status_i  (irq_status),
        .irq_enable_o  (irq_enable),
        .phy_reset_o   (mdio_reset_o)
    );

    mdio_frame_engine frame_engine_i (
        .clock       (clock),
        .reset       (reset),
        .mdio_cmd_i  (mdio_cmd),
        .mdio_rsp_o  (mdio_rsp),
        .mdio_pins_o (mdio_pins_o),
        .mdio_i      (mdio_i)
    );

    mdio_irq_status irq_status_i (
        .clock        (clock),
        .reset        (reset),
        .phy_irq_i    (phy_irq_i),
        .mdio_start_i (mdio_cmd.start),
        .mdio_done_i  (mdio_rsp.done),
        .irq_enable_i (irq_enable),
        .irq_status_o (irq_status),
        .interrupt_o  (interrupt_o)
    );

endmodule

//--- design/mdio_irq_status.sv
/*
 * Interrupt status of the MDIO controller
 * PHY interrupt synchronizer, status word and level interrupt
 */
`timescale 1ns/100ps
`include "mdio_ctrl_consts.svh"

module mdio_irq_status import mdio_ctrl_pkg::*; (
    input  logic      clock,
    input  logic      reset,
    input  logic      phy_irq_i,
    input  logic      mdio_start_i,
    input  logic      mdio_done_i,
    input  reg_word_t irq_enable_i,
    output reg_word_t irq_status_o,
    output logic      interrupt_o
);

    logic [`IRQ_SYNC_STAGES-1:0] irq_sync_q;

    // PHY pin is asynchronous to clock
    always_ff @(posedge clock) begin
        if (reset) begin
            irq_sync_q <= '0;
        end else begin
            irq_sync_q <= {irq_sync_q[`IRQ_SYNC_STAGES-2:0], phy_irq_i};
        end
    end

    always_comb begin
        irq_status_o = '0;
        irq_status_o[`IRQ_PHY_BIT] = irq_sync_q[`IRQ_SYNC_STAGES-1];
        irq_status_o[`IRQ_MDIO_IDLE_BIT] = !mdio_start_i && !mdio_done_i;
    end

    assign interrupt_o = |(irq_enable_i & irq_status_o);

endmodule

//--- design/mdio_frame_engine.sv
/*
 * MDIO management frame engine
 * Fixed divider for MDC, 32 preamble ones then the command MSB first
 * Read frames release the line for the PHY turnaround and data
 */
`timescale 1ns/100ps
`include "mdio_ctrl_consts.svh"

module mdio_frame_engine import mdio_ctrl_pkg::*; (
    input  logic       clock,
    input  logic       reset,
    input  mdio_cmd_t  mdio_cmd_i,
    output mdio_rsp_t  mdio_rsp_o,
    output mdio_pins_t mdio_pins_o,
    input  logic       mdio_i
);

    localparam int DIV_W = $clog2(`MDC_HALF_PERIOD);

    engine_state_t    state_q;
    logic [DIV_W-1:0] div_q;
    frame_bit_t       bit_q;
    frame_bit_t       next_bit;
    mdio_frame_t      frame_q;
    mdio_frame_t      result_q;
    logic             done_q;
    logic             mdc_q;
    logic             data_out_q;
    logic             data_oe_q;
    logic             tick;
    logic             is_read;
    logic             next_out;
    logic             next_oe;
    logic             capture;

    assign tick     = (div_q == '0);
    assign next_bit = bit_q + 1'b1;
    assign is_read  = frame_q[`MDIO_READ_OP_BIT];
    // Rising MDC of a command bit
    assign capture  = mdio_cmd_i.start && state_q == ENG_SHIFT && tick && !mdc_q
                      && bit_q >= frame_bit_t'(`MDIO_PREAMBLE_BITS);

    // Line value for the bit that starts at the next falling MDC
    always_comb begin
        if (next_bit < frame_bit_t'(`MDIO_PREAMBLE_BITS)) begin
            next_out = 1'b1;
        end else begin
            next_out = frame_q[~next_bit[4:0]];
        end
        next_oe = !(is_read && next_bit >= frame_bit_t'(`MDIO_RELEASE_BIT));
    end

    always_ff @(posedge clock) begin
        if (state_q == ENG_IDLE && mdio_cmd_i.start) begin
            frame_q <= mdio_cmd_i.frame;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            result_q <= '0;
        end else if (capture) begin
            result_q[~bit_q[4:0]] <= mdio_i;
        end
    end

    always_ff @(posedge clock) begin
        if (reset || !mdio_cmd_i.start) begin
            state_q    <= ENG_IDLE;
            div_q      <= '0;
            bit_q      <= frame_bit_t'(`MDIO_FRAME_BITS - 1);
            done_q     <= 1'b0;
            mdc_q      <= 1'b0;
            data_out_q <= 1'b1;
            data_oe_q  <= 1'b0;
        end else begin
            case (state_q)
                ENG_IDLE: begin
                    // bit_q wraps to 0 for the first preamble bit
                    div_q      <= DIV_W'(`MDC_HALF_PERIOD - 1);
                    bit_q      <= next_bit;
                    data_out_q <= next_out;
                    data_oe_q  <= next_oe;
                    state_q    <= ENG_SHIFT;
                end
                ENG_SHIFT: begin
                    if (!tick) begin
                        div_q <= div_q - 1'b1;
                    end else begin
                        div_q <= DIV_W'(`MDC_HALF_PERIOD - 1);
                        mdc_q <= !mdc_q;
                        if (mdc_q && bit_q == frame_bit_t'(`MDIO_FRAME_BITS - 1)) begin
                            data_out_q <= 1'b1;
                            data_oe_q  <= 1'b1;
                            state_q    <= ENG_STOP;
                        end else if (mdc_q) begin
                            bit_q      <= next_bit;
                            data_out_q <= next_out;
                            data_oe_q  <= next_oe;
                        end
                    end
                end
                ENG_STOP: begin
                    if (tick) begin
                        done_q  <= 1'b1;
                        state_q <= ENG_DONE;
                    end else begin
                        div_q <= div_q - 1'b1;
                    end
                end
                // Hold done until start falls
                ENG_DONE: ;
                default: state_q <= ENG_IDLE;
            endcase
        end
    end

    assign mdio_rsp_o.done      = done_q;
    assign mdio_rsp_o.result    = result_q;
    assign mdio_pins_o.mdc      = mdc_q;
    assign mdio_pins_o.data_out = data_out_q;
    assign mdio_pins_o.data_oe  = data_oe_q;

endmodule

//--- design/mdio_reg_decode.sv
/*
 * AXI-Lite register slave of the MDIO controller
 * Independent AR, AW and W acceptance, one outstanding read and write
 * Interrupt enable, control and MDIO command registers, read-data mux
 */
`timescale 1ns/100ps
`include "mdio_ctrl_consts.svh"

module mdio_reg_decode import mdio_ctrl_pkg::*; (
    input  logic        clock,
    input  logic        reset,
    input  axil_req_t   axil_req_i,
    output axil_rsp_t   axil_rsp_o,
    output mdio_cmd_t   mdio_cmd_o,
    input  logic        mdio_done_i,
    input  mdio_frame_t mdio_result_i,
    input  reg_word_t   irq_status_i,
    output reg_word_t   irq_enable_o,
    output logic        phy_reset_o
);

    logic      rd_req_q;
    logic      aw_held_q;
    logic      w_held_q;
    logic      rvalid_q;
    logic      bvalid_q;
    reg_addr_t read_addr_q;
    reg_addr_t write_addr_q;
    reg_word_t write_data_q;
    reg_word_t rdata_q;
    reg_word_t read_mux;
    reg_word_t int_enable_q;
    reg_word_t control_q;
    mdio_cmd_t cmd_q;
    logic      arready;
    logic      awready;
    logic      wready;
    logic      read_go;
    logic      write_go;

    // Ready only while nothing of that kind is pending
    assign arready  = !rd_req_q && !rvalid_q;
    assign awready  = !aw_held_q && !bvalid_q;
    assign wready   = !w_held_q && !bvalid_q;
    assign read_go  = rd_req_q && !rvalid_q;
    assign write_go = aw_held_q && w_held_q && !bvalid_q;

    always_comb begin
        case (read_addr_q)
            `REG_INT_ENABLE:  read_mux = int_enable_q;
            `REG_INT_STATUS:  read_mux = irq_status_i;
            `REG_CONTROL:     read_mux = control_q;
            `REG_MDIO_CMD:    read_mux = cmd_q.frame;
            `REG_MDIO_RESULT: read_mux = mdio_result_i;
            default:          read_mux = '0;
        endcase
    end

    // Request payload
    always_ff @(posedge clock) begin
        if (arready && axil_req_i.arvalid) begin
            read_addr_q <= axil_req_i.araddr;
        end
        if (awready && axil_req_i.awvalid) begin
            write_addr_q <= axil_req_i.awaddr;
        end
        if (wready && axil_req_i.wvalid) begin
            write_data_q <= axil_req_i.wdata;
        end
        if (read_go) begin
            rdata_q <= read_mux;
        end
    end

    // Read channel
    always_ff @(posedge clock) begin
        if (reset) begin
            rd_req_q <= 1'b0;
            rvalid_q <= 1'b0;
        end else begin
            if (arready && axil_req_i.arvalid) begin
                rd_req_q <= 1'b1;
            end
            if (rvalid_q && axil_req_i.rready) begin
                rvalid_q <= 1'b0;
            end else if (read_go) begin
                rvalid_q <= 1'b1;
                rd_req_q <= 1'b0;
            end
        end
    end

    // Write channel and register updates
    always_ff @(posedge clock) begin
        if (reset) begin
            aw_held_q    <= 1'b0;
            w_held_q     <= 1'b0;
            bvalid_q     <= 1'b0;
            int_enable_q <= '0;
            control_q    <= '0;
            cmd_q        <= '0;
        end else begin
            if (awready && axil_req_i.awvalid) begin
                aw_held_q <= 1'b1;
            end
            if (wready && axil_req_i.wvalid) begin
                w_held_q <= 1'b1;
            end
            // Drop the start level once the engine is done
            if (cmd_q.start && mdio_done_i) begin
                cmd_q.start <= 1'b0;
            end
            if (bvalid_q && axil_req_i.bready) begin
                bvalid_q <= 1'b0;
            end else if (write_go) begin
                bvalid_q  <= 1'b1;
                aw_held_q <= 1'b0;
                w_held_q  <= 1'b0;
                case (write_addr_q)
                    `REG_INT_ENABLE: int_enable_q <= write_data_q;
                    `REG_CONTROL:    control_q <= write_data_q;
                    `REG_MDIO_CMD: begin
                        cmd_q.frame <= write_data_q;
                        cmd_q.start <= 1'b1;
                    end
                    default: ;
                endcase
            end
        end
    end

    always_comb begin
        axil_rsp_o.awready = awready;
        axil_rsp_o.wready  = wready;
        axil_rsp_o.bvalid  = bvalid_q;
        axil_rsp_o.bresp   = 2'b00;
        axil_rsp_o.arready = arready;
        axil_rsp_o.rvalid  = rvalid_q;
        axil_rsp_o.rdata   = rdata_q;
        axil_rsp_o.rresp   = 2'b00;
    end

    assign mdio_cmd_o   = cmd_q;
    assign irq_enable_o = int_enable_q;
    // Control bit 2 releases the PHY from reset
    assign phy_reset_o  = !control_q[2];

endmodule

//--- design/mdio_ctrl_pkg.sv
/*
 * Shared types of the MDIO controller: vector typedefs,
 * frame engine state and the AXI-Lite, command and pin structs
 */
package mdio_ctrl_pkg;

    typedef logic [11:0] reg_addr_t;
    typedef logic [31:0] reg_word_t;
    typedef logic [31:0] mdio_frame_t;
    typedef logic [5:0]  frame_bit_t;

    typedef enum logic [1:0] {
        ENG_IDLE,
        ENG_SHIFT,
        ENG_STOP,
        ENG_DONE
    } engine_state_t;

    // Host to slave
    typedef struct packed {
        reg_addr_t awaddr;
        logic      awvalid;
        reg_word_t wdata;
        logic      wvalid;
        logic      bready;
        reg_addr_t araddr;
        logic      arvalid;
        logic      rready;
    } axil_req_t;

    // Slave to host
    typedef struct packed {
        logic      awready;
        logic      wready;
        logic      bvalid;
        logic [1:0] bresp;
        logic      arready;
        logic      rvalid;
        reg_word_t rdata;
        logic [1:0] rresp;
    } axil_rsp_t;

    typedef struct packed {
        logic        start;
        mdio_frame_t frame;
    } mdio_cmd_t;

    typedef struct packed {
        logic        done;
        mdio_frame_t result;
    } mdio_rsp_t;

    // Line toward the PHY where data_oe low means released
    typedef struct packed {
        logic mdc;
        logic data_out;
        logic data_oe;
    } mdio_pins_t;

endpackage

//--- design/mdio_ctrl_consts.svh
/*
 * Register byte offsets, MDC divider, MDIO frame layout
 * and interrupt status bit positions
 */
`ifndef MDIO_CTRL_CONSTS_SVH
`define MDIO_CTRL_CONSTS_SVH

// Register map
`define REG_INT_ENABLE      12'h008
`define REG_INT_STATUS      12'h00C
`define REG_CONTROL         12'h020
`define REG_MDIO_CMD        12'h024
`define REG_MDIO_RESULT     12'h028

// Clocks per MDC phase
`define MDC_HALF_PERIOD     25

// Management frame layout
`define MDIO_PREAMBLE_BITS  32
`define MDIO_FRAME_BITS     64
`define MDIO_READ_OP_BIT    29
`define MDIO_RELEASE_BIT    46

// PHY interrupt synchronizer and status bits
`define IRQ_SYNC_STAGES     3
`define IRQ_PHY_BIT         0
`define IRQ_MDIO_IDLE_BIT   1

`endif
